/* all.f */
+incdir+.
motion_pkg.sv
ctrl_if.sv
ir_scan.sv
prop_path.sv
intgrl_path.sv
motor_mixer.sv
motion_cntrl.sv
tb_motion_cntrl.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the motion controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_motion_cntrl \
	-f all.f -o Vtb_motion_cntrl
./obj_dir/Vtb_motion_cntrl 2>&1 | tee sim.log

if grep -q "^test passed$" sim.log; then
	exit 0
else
	exit 1
fi

/* motion_model.svh */
// reference model of the controller math, included inside the testbench module
// keeps integral, round count and forward speed across rounds the way the DUT does
`ifndef MOTION_MODEL_SVH
`define MOTION_MODEL_SVH

motion_pkg::term_t mdl_intgrl;   // retained over go drops
logic [1:0]        mdl_rnd;      // completed rounds, mod 4
motion_pkg::term_t mdl_fwd;

// clamp to the signed 12 bit range of every term
function automatic motion_pkg::term_t clip_term(input int val);
	if (val > 2047)
		return 12'sh7FF;
	else if (val < -2048)
		return 12'sh800;
	else
		return val[11:0];
endfunction

task automatic clear_model();
	mdl_intgrl = '0;
	mdl_rnd    = '0;
	mdl_fwd    = '0;
endtask

// go low only restarts the ramp
task automatic restart_ramp();
	mdl_fwd = '0;
endtask

// rd holds the six readings in scan slot order
task automatic calc_error(input motion_pkg::res_t rd [6], output motion_pkg::term_t err);
	int sum;
	sum = 0;
	for (int s = 0; s < 6; s++) begin
		if (s % 2 == 0)
			sum += int'(rd[s]) << (s / 2);   // right side adds
		else
			sum -= int'(rd[s]) << (s / 2);
	end
	err = clip_term(sum);
endtask

// one completed round, advances the model state
task automatic predict_round(input motion_pkg::res_t rd [6],
		output motion_pkg::motor_t lft, output motion_pkg::motor_t rht);
	motion_pkg::term_t err;
	motion_pkg::term_t pcomp;
	motion_pkg::term_t icomp;
	motion_pkg::term_t lft_mix;
	motion_pkg::term_t rht_mix;
	calc_error(rd, err);
	pcomp = clip_term((int'(err) * int'(motion_pkg::PTERM)) >>> motion_pkg::P_SHIFT);
	if (mdl_rnd == 2'd3)
		mdl_intgrl = clip_term(int'(mdl_intgrl) +
			(int'(err) >>> motion_pkg::INTGRL_SHIFT));
	mdl_rnd = mdl_rnd + 2'd1;
	icomp = clip_term((int'(mdl_intgrl) * int'(motion_pkg::ITERM)) >>>
		motion_pkg::I_SHIFT);
	if (mdl_fwd < motion_pkg::FWD_MAX)
		mdl_fwd = mdl_fwd + 12'sd1;
	rht_mix = clip_term(int'(mdl_fwd) - int'(pcomp) - int'(icomp));
	lft_mix = clip_term(int'(mdl_fwd) + int'(pcomp) + int'(icomp));
	lft = lft_mix[11:1];
	rht = rht_mix[11:1];
endtask

`endif

/* tb_motion_cntrl.sv */
`timescale 1ns/1ps
// testbench for the motion controller, A2D responder with random readings and latency
// checks channel order, emitter gating and motor commands against the reference model
module tb_motion_cntrl;

	localparam int          NUM_ROUNDS     = 24;
	localparam int          TIMEOUT_CYCLES = NUM_ROUNDS * 13000 + 20000;
	localparam logic [31:0] SEED           = 32'ha13408b4;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               go;
	logic               cnv_cmplt;
	motion_pkg::res_t   res;
	logic               ir_in_en;
	logic               ir_mid_en;
	logic               ir_out_en;
	logic               strt_cnv;
	motion_pkg::chnnl_t chnnl;
	motion_pkg::motor_t lft;
	motion_pkg::motor_t rht;

	int                 cycles = 0;
	logic [2:0]         slot_exp;    // slot the DUT is on, 6 right after a round
	motion_pkg::motor_t exp_lft;     // motor values the DUT should hold now
	motion_pkg::motor_t exp_rht;

	`include "motion_model.svh"

	motion_cntrl motion_cntrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.go        (go),
		.cnv_cmplt (cnv_cmplt),
		.res       (res),
		.ir_in_en  (ir_in_en),
		.ir_mid_en (ir_mid_en),
		.ir_out_en (ir_out_en),
		.strt_cnv  (strt_cnv),
		.chnnl     (chnnl),
		.lft       (lft),
		.rht       (rht)
	);

	always #2 clk = ~clk;   // 4 ns period

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic check_chnnl(input motion_pkg::chnnl_t got, input motion_pkg::chnnl_t exp);
		if (got !== exp) begin
			$display("FAIL @%0t: chnnl %0d at strt_cnv, expected %0d", $time, got, exp);
			$display("test failed");
			$fatal(1, "channel mismatch");
		end
	endtask

	task automatic check_enables(input logic in_en, input logic mid_en, input logic out_en,
			input logic [2:0] slot);
		logic [2:0] allowed;
		allowed = go ? (3'b001 << slot[2:1]) : 3'b000;   // slot 6 owns no pair
		if (({out_en, mid_en, in_en} & ~allowed) != 3'b000) begin
			$display("FAIL @%0t: enables out/mid/in %b with go %b in slot %0d", $time,
				{out_en, mid_en, in_en}, go, slot);
			$display("test failed");
			$fatal(1, "emitter enable mismatch");
		end
	endtask

	task automatic check_motor(input motion_pkg::motor_t got_l, input motion_pkg::motor_t got_r,
			input motion_pkg::motor_t mdl_l, input motion_pkg::motor_t mdl_r);
		if (got_l !== mdl_l || got_r !== mdl_r) begin
			$display("FAIL @%0t: lft %0d rht %0d, expected lft %0d rht %0d", $time,
				got_l, got_r, mdl_l, mdl_r);
			$display("test failed");
			$fatal(1, "motor command mismatch");
		end
	endtask

	task automatic check_duty(input int got);
		if (got != int'(motion_pkg::IR_DUTY)) begin
			$display("FAIL @%0t: emitter on for %0d of 256 cycles, expected %0d", $time,
				got, motion_pkg::IR_DUTY);
			$display("test failed");
			$fatal(1, "emitter duty mismatch");
		end
	endtask

	task automatic check_strt(input logic got);
		if (got !== 1'b0) begin
			$display("FAIL @%0t: strt_cnv pulsed while go is low", $time);
			$display("test failed");
			$fatal(1, "conversion started while stopped");
		end
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	function automatic logic pair_enable();
		case (slot_exp[2:1])
			2'd0:    return ir_in_en;
			2'd1:    return ir_mid_en;
			2'd2:    return ir_out_en;
			default: return 1'b0;
		endcase
	endfunction

	task automatic tick();
		@(negedge clk);   // outputs are stable, inputs change here
		check_enables(ir_in_en, ir_mid_en, ir_out_en, slot_exp);
	endtask

	// wait for strt_cnv of slot s, settle waits also measure the PWM duty
	task automatic wait_strt(input int s);
		int   n;
		int   on_cnt;
		logic seen;
		n      = 0;
		on_cnt = 0;
		seen   = 1'b0;
		while (!seen) begin
			tick();
			n++;
			if (n <= 256 && pair_enable())
				on_cnt++;
			if (n == 256)
				check_duty(on_cnt);
			seen = strt_cnv;
		end
		check_chnnl(chnnl, motion_pkg::CHNNL_ORDER[s]);
		if (s == 0)
			check_motor(lft, rht, exp_lft, exp_rht);   // result of the previous round
	endtask

	// A2D responder for one conversion
	task automatic convert(input motion_pkg::res_t val);
		int lat;
		lat = int'($urandom_range(1, 20));
		repeat (lat) tick();
		cnv_cmplt = 1'b1;
		res       = val;
		slot_exp  = slot_exp + 3'd1;   // DUT slot moves on this cnv_cmplt
		tick();
		cnv_cmplt = 1'b0;
	endtask

	task automatic stop_and_restart();
		repeat (5) tick();   // inside the gap, no conversion pending
		go      = 1'b0;
		exp_lft = '0;
		exp_rht = '0;
		restart_ramp();
		repeat (300) begin
			tick();
			check_strt(strt_cnv);
			check_motor(lft, rht, exp_lft, exp_rht);
		end
		go       = 1'b1;
		slot_exp = '0;   // restart clears the slot
	endtask

	// mode 0 random, 1 right side full scale, 2 left side full scale
	task automatic do_round(input int mode, input logic abort);
		motion_pkg::res_t   rd [6];
		motion_pkg::motor_t mdl_l;
		motion_pkg::motor_t mdl_r;
		logic               cut;
		cut = 1'b0;
		for (int s = 0; s < 6; s++) begin
			if (mode == 1)
				rd[s] = (s % 2 == 0) ? 12'hFFF : 12'h000;
			else if (mode == 2)
				rd[s] = (s % 2 == 0) ? 12'h000 : 12'hFFF;
			else
				rd[s] = motion_pkg::res_t'($urandom_range(0, 4095));
		end
		for (int s = 0; s < 6 && !cut; s++) begin
			wait_strt(s);
			convert(rd[s]);
			if (abort && s == 2) begin
				stop_and_restart();
				cut = 1'b1;
			end
		end
		if (!cut) begin
			predict_round(rd, mdl_l, mdl_r);
			exp_lft  = mdl_l;
			exp_rht  = mdl_r;
			slot_exp = '0;           // next round starts right after err_valid
			repeat (4) tick();       // past the mixer deadline
			check_motor(lft, rht, exp_lft, exp_rht);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n     = 1'b0;
		go        = 1'b0;
		cnv_cmplt = 1'b0;
		res       = '0;
		slot_exp  = '0;
		exp_lft   = '0;
		exp_rht   = '0;
		clear_model();
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		tick();
		check_strt(strt_cnv);
		check_motor(lft, rht, exp_lft, exp_rht);
		go = 1'b1;
		for (int r = 0; r < NUM_ROUNDS; r++) begin
			if (r == 12)
				do_round(0, 1'b1);   // aborted round, then the full one
			do_round((r == 6) ? 1 : (r == 7) ? 2 : 0, 1'b0);
		end
		$display("test passed");
		$finish;
	end

endmodule

/* motion_cntrl.sv */
`timescale 1ns/1ps
// motion controller top: sensor scan feeding parallel P and I paths and the motor mixer
module motion_cntrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               go,          // run request from the command side
	input  logic               cnv_cmplt,   // A2D result ready
	input  motion_pkg::res_t   res,
	output logic               ir_in_en,
	output logic               ir_mid_en,
	output logic               ir_out_en,
	output logic               strt_cnv,
	output motion_pkg::chnnl_t chnnl,
	output motion_pkg::motor_t lft,
	output motion_pkg::motor_t rht
);

	ctrl_if ctrl_bus ();   // error and term results between the blocks

	ir_scan ir_scan_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.go        (go),
		.cnv_cmplt (cnv_cmplt),
		.res       (res),
		.ir_in_en  (ir_in_en),
		.ir_mid_en (ir_mid_en),
		.ir_out_en (ir_out_en),
		.strt_cnv  (strt_cnv),
		.chnnl     (chnnl),
		.ctrl      (ctrl_bus.scan)
	);

	prop_path prop_path_i (
		.clk   (clk),
		.rst_n (rst_n),
		.ctrl  (ctrl_bus.prop)
	);

	intgrl_path intgrl_path_i (
		.clk   (clk),
		.rst_n (rst_n),
		.ctrl  (ctrl_bus.intgrl)
	);

	motor_mixer motor_mixer_i (
		.clk   (clk),
		.rst_n (rst_n),
		.go    (go),
		.ctrl  (ctrl_bus.mixer),
		.lft   (lft),
		.rht   (rht)
	);

endmodule

/* motor_mixer.sv */
`timescale 1ns/1ps
// forward speed ramp and P/I mix into signed left and right motor commands
// outputs update one cycle after i_valid and read zero while go is low
module motor_mixer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               go,
	ctrl_if.mixer              ctrl,
	output motion_pkg::motor_t lft,
	output motion_pkg::motor_t rht
);

	motion_pkg::term_t  fwd;        // forward speed, one step per round
	motion_pkg::term_t  fwd_nxt;
	motion_pkg::term_t  lft_reg;
	motion_pkg::term_t  rht_reg;
	logic signed [31:0] fwd_ext;
	logic signed [31:0] p_ext;
	logic signed [31:0] i_ext;
	logic signed [31:0] lft_sum;
	logic signed [31:0] rht_sum;

	assign fwd_nxt = (fwd < motion_pkg::FWD_MAX) ? fwd + 12'sd1 : fwd;   // hold at ceiling

	assign fwd_ext = fwd_nxt;
	assign p_ext   = ctrl.pcomp;
	assign i_ext   = ctrl.icomp;
	assign rht_sum = fwd_ext - p_ext - i_ext;   // positive error steers right wheel down
	assign lft_sum = fwd_ext + p_ext + i_ext;

	// ==================================================
	// ramp and output registers
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fwd     <= '0;
			lft_reg <= '0;
			rht_reg <= '0;
		end else if (!go) begin
			fwd     <= '0;   // restart the ramp from standstill
			lft_reg <= '0;
			rht_reg <= '0;
		end else if (ctrl.i_valid) begin
			fwd     <= fwd_nxt;
			lft_reg <= motion_pkg::sat_term(lft_sum);
			rht_reg <= motion_pkg::sat_term(rht_sum);
		end
	end

	// drop the lsb, motor drive takes 11 bits
	assign lft = lft_reg[11:1];
	assign rht = rht_reg[11:1];

	a_stop_zero : assert property (@(posedge clk) disable iff (!rst_n)
		!go |=> (lft == '0 && rht == '0));

endmodule

/* intgrl_path.sv */
`timescale 1ns/1ps
// integral path: the integral moves on every fourth error, icomp follows every round
// i_valid lands two cycles after err_valid
module intgrl_path (
	input logic     clk,
	input logic     rst_n,
	ctrl_if.intgrl  ctrl
);

	logic [1:0]         rnd_cnt;    // only reset clears it, survives go drops
	logic               i_pend;     // integral settled, icomp due
	motion_pkg::term_t  intgrl;
	logic signed [31:0] err_ext;
	logic signed [31:0] intgrl_ext;
	logic signed [31:0] intgrl_sum;
	logic signed [31:0] i_prod;
	logic signed [31:0] i_scl;

	assign err_ext    = ctrl.error;
	assign intgrl_ext = intgrl;
	assign intgrl_sum = intgrl_ext + (err_ext >>> motion_pkg::INTGRL_SHIFT);

	assign i_prod = intgrl_ext * motion_pkg::ITERM;   // uses the already updated integral
	assign i_scl  = i_prod >>> motion_pkg::I_SHIFT;

	// ==================================================
	// decimated integral
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rnd_cnt      <= '0;
			intgrl       <= '0;
			i_pend       <= 1'b0;
			ctrl.i_valid <= 1'b0;
		end else begin
			i_pend       <= ctrl.err_valid;
			ctrl.i_valid <= i_pend;
			if (ctrl.err_valid) begin
				rnd_cnt <= rnd_cnt + 2'd1;
				if (&rnd_cnt)   // fourth round
					intgrl <= motion_pkg::sat_term(intgrl_sum);
			end
		end
	end

	// icomp only changes together with i_valid
	always_ff @(posedge clk) begin
		if (i_pend)
			ctrl.icomp <= motion_pkg::sat_term(i_scl);
	end

endmodule

/* prop_path.sv */
`timescale 1ns/1ps
// proportional term: error times PTERM, scaled down and clipped to the term range
// result and p_valid come one cycle after err_valid
module prop_path (
	input logic   clk,
	input logic   rst_n,
	ctrl_if.prop  ctrl
);

	logic signed [31:0] err_ext;
	logic signed [31:0] p_prod;
	logic signed [31:0] p_scl;

	assign err_ext = ctrl.error;                           // sign extend
	assign p_prod  = err_ext * motion_pkg::PTERM;           // at most ~28.6M, fits easily
	assign p_scl   = p_prod >>> motion_pkg::P_SHIFT;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ctrl.p_valid <= 1'b0;
		else
			ctrl.p_valid <= ctrl.err_valid;
	end

	// term register, loaded only on a fresh error
	always_ff @(posedge clk) begin
		if (ctrl.err_valid)
			ctrl.pcomp <= motion_pkg::sat_term(p_scl);
	end

	// pcomp arrives one cycle after err_valid and keeps the sign of the error
	a_p_follows : assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.p_valid == $past(ctrl.err_valid) &&
		(!ctrl.p_valid || ctrl.pcomp[11] == $past(ctrl.error[11])));

endmodule

/* ir_scan.sv */
`timescale 1ns/1ps
// IR sensor scan: six A2D conversions per round with PWM gated emitters
// accumulates the weighted readings and hands the saturated error to the term paths
module ir_scan (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               go,
	input  logic               cnv_cmplt,
	input  motion_pkg::res_t   res,
	output logic               ir_in_en,
	output logic               ir_mid_en,
	output logic               ir_out_en,
	output logic               strt_cnv,
	output motion_pkg::chnnl_t chnnl,
	ctrl_if.scan               ctrl
);

	motion_pkg::scan_state_t state;
	logic [12:0]        timer;       // settle / gap wait
	logic [2:0]         slot;        // 0..5, even right, odd left
	logic [7:0]         pwm_cnt;     // free running emitter PWM
	logic               pwm;
	logic               rnd_start;
	logic               cnv_sample;  // a conversion result is taken this cycle
	logic               last_slot;
	motion_pkg::accum_t accum;
	motion_pkg::accum_t weighted;
	motion_pkg::accum_t accum_nxt;

	// ==================================================
	// emitter PWM and pair enables
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pwm_cnt <= '0;
		else
			pwm_cnt <= pwm_cnt + 8'd1;
	end

	assign pwm = (pwm_cnt < motion_pkg::IR_DUTY);

	// slot[2:1] names the pair, slot 6 after a round owns no pair
	assign ir_in_en  = go && pwm && (slot[2:1] == 2'd0);
	assign ir_mid_en = go && pwm && (slot[2:1] == 2'd1);
	assign ir_out_en = go && pwm && (slot[2:1] == 2'd2);

	assign chnnl = (slot < 3'd6) ? motion_pkg::CHNNL_ORDER[slot] : motion_pkg::CHNNL_ORDER[5];

	// ==================================================
	// sequencer
	// ==================================================
	assign rnd_start  = go && (state == motion_pkg::SCAN_IDLE || state == motion_pkg::SCAN_DONE);
	assign cnv_sample = go && cnv_cmplt &&
		(state == motion_pkg::SCAN_CNV_RHT || state == motion_pkg::SCAN_CNV_LFT);
	assign last_slot  = (slot == 3'd5);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state          <= motion_pkg::SCAN_IDLE;
			timer          <= '0;
			slot           <= '0;
			strt_cnv       <= 1'b0;
			ctrl.err_valid <= 1'b0;
		end else begin
			strt_cnv       <= 1'b0;   // single cycle pulses
			ctrl.err_valid <= 1'b0;
			timer          <= timer + 13'd1;
			if (!go) begin
				state <= motion_pkg::SCAN_IDLE;   // abort, slot and accum are dropped at restart
			end else if (rnd_start) begin
				state <= motion_pkg::SCAN_SETTLE;
				timer <= '0;
				slot  <= '0;
			end else begin
				case (state)
					motion_pkg::SCAN_SETTLE:
						if (timer == 13'(motion_pkg::SETTLE_CYCLES - 1)) begin
							strt_cnv <= 1'b1;     // right side of the pair
							state    <= motion_pkg::SCAN_CNV_RHT;
						end
					motion_pkg::SCAN_CNV_RHT:
						if (cnv_cmplt) begin
							slot  <= slot + 3'd1;
							timer <= 13'd1;       // timer now counts cycles since cnv_cmplt
							state <= motion_pkg::SCAN_GAP;
						end
					motion_pkg::SCAN_GAP:
						if (timer == 13'(motion_pkg::GAP_CYCLES - 1)) begin
							strt_cnv <= 1'b1;     // left side
							state    <= motion_pkg::SCAN_CNV_LFT;
						end
					motion_pkg::SCAN_CNV_LFT:
						if (cnv_cmplt) begin
							slot  <= slot + 3'd1;
							timer <= '0;
							if (last_slot) begin
								ctrl.err_valid <= 1'b1;
								state          <= motion_pkg::SCAN_DONE;
							end else begin
								state <= motion_pkg::SCAN_SETTLE;   // next pair
							end
						end
					default:
						state <= motion_pkg::SCAN_IDLE;
				endcase
			end
		end
	end

	// ==================================================
	// weighted error
	// ==================================================
	// weights 1/2/4 for inner/middle/outer come straight from the pair index
	assign weighted  = motion_pkg::accum_t'({4'd0, res}) << slot[2:1];
	assign accum_nxt = slot[0] ? (accum - weighted) : (accum + weighted);  // left subtracts

	always_ff @(posedge clk) begin
		if (rnd_start)
			accum <= '0;
		else if (cnv_sample)
			accum <= accum_nxt;
		if (cnv_sample && last_slot)
			ctrl.error <= motion_pkg::sat_term(accum_nxt);   // lines up with err_valid
	end

	a_strt_single : assert property (@(posedge clk) disable iff (!rst_n)
		strt_cnv |=> !strt_cnv);

	a_one_pair : assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({ir_in_en, ir_mid_en, ir_out_en}));

endmodule

/* ctrl_if.sv */
`timescale 1ns/1ps
// internal bus from the sensor scan to the P and I paths and on to the motor mixer
// each valid is a single cycle pulse, data holds until the next one
interface ctrl_if;

	motion_pkg::term_t error;    // saturated weighted line error
	logic              err_valid;
	motion_pkg::term_t pcomp;    // proportional term
	logic              p_valid;
	motion_pkg::term_t icomp;    // integral term
	logic              i_valid;

	modport scan (
		output error, err_valid
	);

	modport prop (
		input  error, err_valid,
		output pcomp, p_valid
	);

	modport intgrl (
		input  error, err_valid,
		output icomp, i_valid
	);

	// mixer fires on i_valid, pcomp is already stable one cycle earlier
	modport mixer (
		input pcomp, icomp, i_valid
	);

endinterface

/* motion_pkg.sv */
// shared widths, types, timing and gain constants for the line follower motion controller
// every design and testbench file picks these up by scoped name
package motion_pkg;

	// ==================================================
	// data types
	// ==================================================
	typedef logic [11:0]        res_t;     // raw A2D reading
	typedef logic [2:0]         chnnl_t;   // A2D mux address
	typedef logic signed [15:0] accum_t;   // weighted sum of one round
	typedef logic signed [11:0] term_t;    // error, integral, terms, fwd, mixed motor
	typedef logic signed [10:0] motor_t;   // motor command as driven out

	// scan sequencer states
	typedef enum logic [2:0] {
		SCAN_IDLE,
		SCAN_SETTLE,    // pair settle wait
		SCAN_CNV_RHT,
		SCAN_GAP,       // short wait between sides
		SCAN_CNV_LFT,
		SCAN_DONE
	} scan_state_t;

	// ==================================================
	// timing
	// ==================================================
	localparam int SETTLE_CYCLES = 4096;        // pair start to right strt_cnv
	localparam int GAP_CYCLES    = 32;          // right cnv_cmplt to left strt_cnv
	localparam logic [7:0] IR_DUTY = 8'h8C;     // emitter on time out of 256

	// A2D channel per scan slot, right/left for inner, middle, outer
	localparam chnnl_t CHNNL_ORDER [0:5] = '{3'd1, 3'd0, 3'd4, 3'd2, 3'd3, 3'd7};

	// ==================================================
	// loop gains
	// ==================================================
	localparam logic signed [15:0] PTERM = 16'sd13952;   // 0x3680
	localparam int P_SHIFT      = 13;
	localparam logic signed [15:0] ITERM = 16'sd1280;    // 0x500
	localparam int I_SHIFT      = 12;
	localparam int INTGRL_SHIFT = 4;                     // error scaling into the integral
	localparam term_t FWD_MAX   = 12'sd1792;             // forward ramp ceiling

	localparam term_t TERM_MAX = 12'sh7FF;
	localparam term_t TERM_MIN = 12'sh800;

	// clip any wide signed result into the 12 bit term range
	function automatic term_t sat_term(input logic signed [31:0] val);
		if (val > TERM_MAX)
			return TERM_MAX;
		else if (val < TERM_MIN)
			return TERM_MIN;
		else
			return val[11:0];
	endfunction

endpackage
